//--- design/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // ==================================================
    // widths
    // ==================================================
    localparam int xlen   = 32;
    localparam int ilen   = 32;
    localparam int reg_aw = 5;
    localparam int alu_w  = 16;
    localparam int opc_w  = 11;
    localparam int exc_w  = 4;

    localparam logic [xlen-1:0] reset_pc = '0;

    // ==================================================
    // one-hot bit indexes
    // ==================================================
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_xor  = 4;
    localparam int alu_or   = 5;
    localparam int alu_and  = 6;
    localparam int alu_sll  = 7;
    localparam int alu_srl  = 8;
    localparam int alu_sra  = 9;
    localparam int alu_eq   = 10;
    localparam int alu_neq  = 11;
    localparam int alu_lt   = 12;
    localparam int alu_ltu  = 13;
    localparam int alu_ge   = 14;
    localparam int alu_geu  = 15;

    localparam int cls_rtype  = 0;
    localparam int cls_itype  = 1;
    localparam int cls_load   = 2;
    localparam int cls_store  = 3;
    localparam int cls_branch = 4;
    localparam int cls_jal    = 5;
    localparam int cls_jalr   = 6;
    localparam int cls_lui    = 7;
    localparam int cls_auipc  = 8;
    localparam int cls_system = 9;
    localparam int cls_fence  = 10;

    localparam int exc_illegal = 0;
    localparam int exc_ecall   = 1;
    localparam int exc_ebreak  = 2;
    localparam int exc_mret    = 3;

    // ==================================================
    // rv32i encodings
    // ==================================================
    localparam logic [6:0] opcode_rtype  = 7'b0110011;
    localparam logic [6:0] opcode_itype  = 7'b0010011;
    localparam logic [6:0] opcode_load   = 7'b0000011;
    localparam logic [6:0] opcode_store  = 7'b0100011;
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_jal    = 7'b1101111;
    localparam logic [6:0] opcode_jalr   = 7'b1100111;
    localparam logic [6:0] opcode_lui    = 7'b0110111;
    localparam logic [6:0] opcode_auipc  = 7'b0010111;
    localparam logic [6:0] opcode_system = 7'b1110011;
    localparam logic [6:0] opcode_fence  = 7'b0001111;

    // alu group, srl and sra share funct3_sr
    localparam logic [2:0] funct3_add  = 3'b000;
    localparam logic [2:0] funct3_sll  = 3'b001;
    localparam logic [2:0] funct3_slt  = 3'b010;
    localparam logic [2:0] funct3_sltu = 3'b011;
    localparam logic [2:0] funct3_xor  = 3'b100;
    localparam logic [2:0] funct3_sr   = 3'b101;
    localparam logic [2:0] funct3_or   = 3'b110;
    localparam logic [2:0] funct3_and  = 3'b111;
    // branch group
    localparam logic [2:0] funct3_eq   = 3'b000;
    localparam logic [2:0] funct3_neq  = 3'b001;
    localparam logic [2:0] funct3_lt   = 3'b100;
    localparam logic [2:0] funct3_ge   = 3'b101;
    localparam logic [2:0] funct3_ltu  = 3'b110;
    localparam logic [2:0] funct3_geu  = 3'b111;
    // system group with no csr access
    localparam logic [2:0] funct3_priv = 3'b000;

    localparam logic [6:0] funct7_base = 7'h00;
    localparam logic [6:0] funct7_alt  = 7'h20;

    localparam logic [11:0] sys_ecall  = 12'h000;
    localparam logic [11:0] sys_ebreak = 12'h001;
    localparam logic [11:0] sys_mret   = 12'h302;

endpackage

`default_nettype wire

//--- design/rv_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module rv_fetch (
    input  logic                    d_clk,
    input  logic                    d_rst,
    input  logic                    stall,
    input  logic                    redirect,
    input  logic [rv_pkg::xlen-1:0] redirect_pc,
    output logic [rv_pkg::xlen-1:0] imem_addr,
    output logic [rv_pkg::xlen-1:0] if_pc,
    output logic                    if_ce
);
    import rv_pkg::*;

    logic [xlen-1:0] next_addr;

    // ==================================================
    // program counter
    // ==================================================
    always_comb begin
        if (redirect) begin
            next_addr = redirect_pc;
        end else begin
            next_addr = imem_addr + xlen'(4);
        end
    end

    always_ff @(posedge d_clk or negedge d_rst) begin
        if (!d_rst) begin
            imem_addr <= reset_pc;
        end else if (!stall) begin
            imem_addr <= next_addr;
        end
    end

    // ==================================================
    // word in flight
    // ==================================================
    // the memory samples imem_addr on this edge, so its word comes back next cycle
    always_ff @(posedge d_clk or negedge d_rst) begin
        if (!d_rst) begin
            if_ce <= 1'b0;
        end else if (!stall) begin
            // a redirect kills the word fetched from the old path
            if_ce <= !redirect;
        end
    end

    always_ff @(posedge d_clk) begin
        if (!stall) begin
            if_pc <= imem_addr;
        end
    end

    a_addr_aligned : assert property (
        @(posedge d_clk) disable iff (!d_rst)
        imem_addr[1:0] == 2'b00
    );

endmodule

`default_nettype wire

//--- design/rv_decode.sv
`timescale 1ns/1ns
`default_nettype none

module rv_decode (
    input  logic                      d_clk,
    input  logic                      d_rst,
    input  logic [rv_pkg::ilen-1:0]   if_instr,
    input  logic [rv_pkg::xlen-1:0]   if_pc,
    input  logic                      if_ce,
    input  logic                      stall,
    input  logic                      redirect,
    output logic [rv_pkg::reg_aw-1:0] rs1_addr,
    output logic [rv_pkg::reg_aw-1:0] rs2_addr,
    output logic                      id_valid,
    output logic [rv_pkg::xlen-1:0]   id_pc,
    output logic [rv_pkg::reg_aw-1:0] id_rs1,
    output logic [rv_pkg::reg_aw-1:0] id_rs2,
    output logic [rv_pkg::reg_aw-1:0] id_rd,
    output logic [rv_pkg::xlen-1:0]   id_imm,
    output logic [2:0]                id_funct3,
    output logic [rv_pkg::alu_w-1:0]  id_alu,
    output logic [rv_pkg::opc_w-1:0]  id_class,
    output logic [rv_pkg::exc_w-1:0]  id_exception
);
    import rv_pkg::*;

    logic [ilen-1:0]   held_instr;
    logic              held_q;
    logic [ilen-1:0]   instr;
    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic [11:0]       sys_imm;
    logic              uses_rs1;
    logic              uses_rs2;
    logic              uses_rd;
    logic              shift_imm;
    logic [reg_aw-1:0] rd_d;
    logic [2:0]        funct3_d;
    logic [xlen-1:0]   imm_d;
    logic [alu_w-1:0]  alu_d;
    logic [opc_w-1:0]  cls_d;
    logic [exc_w-1:0]  exc_d;

    // ==================================================
    // instruction hold
    // ==================================================
    // imem keeps reading during a stall and overwrites the word on if_instr,
    // so the word seen on the first stalled edge is kept until the stall ends
    always_ff @(posedge d_clk or negedge d_rst) begin
        if (!d_rst) begin
            held_q <= 1'b0;
        end else begin
            held_q <= stall;
        end
    end

    always_ff @(posedge d_clk) begin
        if (stall && !held_q) begin
            held_instr <= if_instr;
        end
    end

    assign instr   = held_q ? held_instr : if_instr;
    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign sys_imm = instr[31:20];

    // ==================================================
    // opcode class, fields and immediate
    // ==================================================
    always_comb begin
        cls_d = '0;
        imm_d = '0;
        case (opcode)
            opcode_rtype: cls_d[cls_rtype] = 1'b1;
            opcode_itype: begin
                cls_d[cls_itype] = 1'b1;
                imm_d = {{20{instr[31]}}, instr[31:20]};
            end
            opcode_load: begin
                cls_d[cls_load] = 1'b1;
                imm_d = {{20{instr[31]}}, instr[31:20]};
            end
            opcode_jalr: begin
                cls_d[cls_jalr] = 1'b1;
                imm_d = {{20{instr[31]}}, instr[31:20]};
            end
            opcode_store: begin
                cls_d[cls_store] = 1'b1;
                imm_d = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            opcode_branch: begin
                cls_d[cls_branch] = 1'b1;
                imm_d = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            opcode_jal: begin
                cls_d[cls_jal] = 1'b1;
                imm_d = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            opcode_lui: begin
                cls_d[cls_lui] = 1'b1;
                imm_d = {instr[31:12], 12'h000};
            end
            opcode_auipc: begin
                cls_d[cls_auipc] = 1'b1;
                imm_d = {instr[31:12], 12'h000};
            end
            opcode_system: begin
                cls_d[cls_system] = 1'b1;
                imm_d = {20'h00000, instr[31:20]};
            end
            opcode_fence: begin
                cls_d[cls_fence] = 1'b1;
                imm_d = {20'h00000, instr[31:20]};
            end
            default: cls_d = '0;
        endcase
    end

    // unknown opcodes select no class, so every field falls to zero
    assign uses_rs2 = cls_d[cls_rtype] | cls_d[cls_store] | cls_d[cls_branch];
    assign uses_rs1 = uses_rs2 | cls_d[cls_itype] | cls_d[cls_load] | cls_d[cls_jalr]
                    | cls_d[cls_system] | cls_d[cls_fence];
    assign uses_rd  = (|cls_d) & !cls_d[cls_store] & !cls_d[cls_branch];

    assign rs1_addr = uses_rs1 ? instr[19:15] : '0;
    assign rs2_addr = uses_rs2 ? instr[24:20] : '0;
    assign rd_d     = uses_rd ? instr[11:7] : '0;
    assign funct3_d = uses_rs1 ? funct3 : 3'b000;

    // ==================================================
    // alu operation
    // ==================================================
    always_comb begin
        alu_d = '0;
        if (cls_d[cls_rtype] || cls_d[cls_itype]) begin
            case (funct3)
                funct3_add:  alu_d[(cls_d[cls_rtype] && instr[30]) ? alu_sub : alu_add] = 1'b1;
                funct3_sll:  alu_d[alu_sll] = 1'b1;
                funct3_slt:  alu_d[alu_slt] = 1'b1;
                funct3_sltu: alu_d[alu_sltu] = 1'b1;
                funct3_xor:  alu_d[alu_xor] = 1'b1;
                funct3_sr:   alu_d[instr[30] ? alu_sra : alu_srl] = 1'b1;
                funct3_or:   alu_d[alu_or] = 1'b1;
                default:     alu_d[alu_and] = 1'b1;
            endcase
        end else if (cls_d[cls_branch]) begin
            case (funct3)
                funct3_eq:  alu_d[alu_eq] = 1'b1;
                funct3_neq: alu_d[alu_neq] = 1'b1;
                funct3_lt:  alu_d[alu_lt] = 1'b1;
                funct3_ge:  alu_d[alu_ge] = 1'b1;
                funct3_ltu: alu_d[alu_ltu] = 1'b1;
                funct3_geu: alu_d[alu_geu] = 1'b1;
                // 010 and 011 have no compare, fall back to add
                default:    alu_d[alu_add] = 1'b1;
            endcase
        end else begin
            alu_d[alu_add] = 1'b1;
        end
    end

    // ==================================================
    // exceptions
    // ==================================================
    assign shift_imm = cls_d[cls_itype] && (funct3 == funct3_sll || funct3 == funct3_sr);

    always_comb begin
        exc_d = '0;
        if (cls_d == '0) begin
            exc_d[exc_illegal] = 1'b1;
        end else if (cls_d[cls_rtype] && funct7 != funct7_base && funct7 != funct7_alt) begin
            exc_d[exc_illegal] = 1'b1;
        end else if (shift_imm && funct7 != funct7_base
                     && (funct3 == funct3_sll || funct7 != funct7_alt)) begin
            // slli only takes funct7 zero
            exc_d[exc_illegal] = 1'b1;
        end else if (cls_d[cls_system] && funct3 == funct3_priv) begin
            case (sys_imm)
                sys_ecall:  exc_d[exc_ecall] = 1'b1;
                sys_ebreak: exc_d[exc_ebreak] = 1'b1;
                sys_mret:   exc_d[exc_mret] = 1'b1;
                default:    exc_d[exc_illegal] = 1'b1;
            endcase
        end
    end

    // ==================================================
    // output stage
    // ==================================================
    always_ff @(posedge d_clk or negedge d_rst) begin
        if (!d_rst) begin
            id_valid     <= 1'b0;
            id_alu       <= '0;
            id_class     <= '0;
            id_exception <= '0;
        end else if (!stall) begin
            id_valid     <= if_ce && !redirect;
            id_alu       <= alu_d;
            id_class     <= cls_d;
            id_exception <= (if_ce && !redirect) ? exc_d : '0;
        end
    end

    always_ff @(posedge d_clk) begin
        if (!stall) begin
            id_pc     <= if_pc;
            id_rs1    <= rs1_addr;
            id_rs2    <= rs2_addr;
            id_rd     <= rd_d;
            id_imm    <= imm_d;
            id_funct3 <= funct3_d;
        end
    end

    a_class_onehot0 : assert property (
        @(posedge d_clk) disable iff (!d_rst)
        $onehot0(id_class)
    );

    a_alu_onehot : assert property (
        @(posedge d_clk) disable iff (!d_rst)
        id_valid |-> $onehot(id_alu)
    );

endmodule

`default_nettype wire

//--- design/rv_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module rv_regfile (
    input  logic                      d_clk,
    input  logic                      d_rst,
    input  logic                      stall,
    input  logic [rv_pkg::reg_aw-1:0] rs1_addr,
    input  logic [rv_pkg::reg_aw-1:0] rs2_addr,
    input  logic                      wb_en,
    input  logic [rv_pkg::reg_aw-1:0] wb_addr,
    input  logic [rv_pkg::xlen-1:0]   wb_data,
    output logic [rv_pkg::xlen-1:0]   rs1_data,
    output logic [rv_pkg::xlen-1:0]   rs2_data
);
    import rv_pkg::*;

    // x0 has no storage
    logic [xlen-1:0] regs [1:(2**reg_aw)-1];

    // read value for one port, with write-to-read bypass
    function automatic logic [xlen-1:0] read_port(input logic [reg_aw-1:0] addr);
        logic [xlen-1:0] value;
        value = '0;
        if (addr != '0) begin
            if (wb_en && wb_addr == addr) begin
                value = wb_data;
            end else begin
                value = regs[addr];
            end
        end
        return value;
    endfunction

    always_ff @(posedge d_clk or negedge d_rst) begin
        if (!d_rst) begin
            for (int i = 1; i < 2**reg_aw; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_addr != '0) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // read data lines up with the registered decode outputs
    always_ff @(posedge d_clk) begin
        if (!stall) begin
            rs1_data <= read_port(rs1_addr);
            rs2_data <= read_port(rs2_addr);
        end
    end

    a_x0_rs1 : assert property (
        @(posedge d_clk) disable iff (!d_rst)
        !stall && rs1_addr == '0 |=> rs1_data == '0
    );

    a_x0_rs2 : assert property (
        @(posedge d_clk) disable iff (!d_rst)
        !stall && rs2_addr == '0 |=> rs2_data == '0
    );

endmodule

`default_nettype wire

//--- design/rv_frontend.sv
`timescale 1ns/1ns
`default_nettype none

module rv_frontend (
    input  logic                      d_clk,
    input  logic                      d_rst,
    input  logic                      stall,
    input  logic                      redirect,
    input  logic [rv_pkg::xlen-1:0]   redirect_pc,
    output logic [rv_pkg::xlen-1:0]   imem_addr,
    input  logic [rv_pkg::ilen-1:0]   imem_rdata,
    input  logic                      wb_en,
    input  logic [rv_pkg::reg_aw-1:0] wb_addr,
    input  logic [rv_pkg::xlen-1:0]   wb_data,
    output logic                      id_valid,
    output logic [rv_pkg::xlen-1:0]   id_pc,
    output logic [rv_pkg::reg_aw-1:0] id_rs1,
    output logic [rv_pkg::reg_aw-1:0] id_rs2,
    output logic [rv_pkg::reg_aw-1:0] id_rd,
    output logic [rv_pkg::xlen-1:0]   id_imm,
    output logic [2:0]                id_funct3,
    output logic [rv_pkg::alu_w-1:0]  id_alu,
    output logic [rv_pkg::opc_w-1:0]  id_class,
    output logic [rv_pkg::exc_w-1:0]  id_exception,
    output logic [rv_pkg::xlen-1:0]   id_rs1_data,
    output logic [rv_pkg::xlen-1:0]   id_rs2_data
);
    import rv_pkg::*;

    logic [xlen-1:0]   if_pc;
    logic              if_ce;
    logic [reg_aw-1:0] rs1_addr;
    logic [reg_aw-1:0] rs2_addr;

    rv_fetch i_fetch (
        .d_clk       (d_clk),
        .d_rst       (d_rst),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_addr   (imem_addr),
        .if_pc       (if_pc),
        .if_ce       (if_ce)
    );

    // if_instr is the memory read data itself
    rv_decode i_decode (
        .d_clk        (d_clk),
        .d_rst        (d_rst),
        .if_instr     (imem_rdata),
        .if_pc        (if_pc),
        .if_ce        (if_ce),
        .stall        (stall),
        .redirect     (redirect),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .id_valid     (id_valid),
        .id_pc        (id_pc),
        .id_rs1       (id_rs1),
        .id_rs2       (id_rs2),
        .id_rd        (id_rd),
        .id_imm       (id_imm),
        .id_funct3    (id_funct3),
        .id_alu       (id_alu),
        .id_class     (id_class),
        .id_exception (id_exception)
    );

    rv_regfile i_regfile (
        .d_clk    (d_clk),
        .d_rst    (d_rst),
        .stall    (stall),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data),
        .rs1_data (id_rs1_data),
        .rs2_data (id_rs2_data)
    );

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int period_ns = 4
) (
    output logic d_clk
);

    initial begin
        d_clk = 1'b0;
    end

    always begin
        #(period_ns / 2);
        d_clk = ~d_clk;
    end

endmodule

`default_nettype wire

//--- test/tb_rv_frontend.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv_frontend;
    import rv_pkg::*;

    // ==================================================
    // run length
    // ==================================================
    localparam int clk_period   = 4;
    localparam int reset_cycles = 16;
    localparam int len_fetch    = 200;
    localparam int len_operand  = 300;
    localparam int len_stall    = 300;
    localparam int len_redirect = 300;
    localparam int len_mixed    = 600;
    localparam int total_cycles = reset_cycles + len_fetch + len_operand + len_stall
                                + len_redirect + len_mixed;
    localparam int watchdog_ns  = (total_cycles + 100) * clk_period;

    logic                d_clk;
    logic                d_rst;
    logic                stall;
    logic                redirect;
    logic [xlen-1:0]     redirect_pc;
    logic [xlen-1:0]     imem_addr;
    logic [ilen-1:0]     imem_rdata = '0;
    logic                wb_en;
    logic [reg_aw-1:0]   wb_addr;
    logic [xlen-1:0]     wb_data;
    logic                id_valid;
    logic [xlen-1:0]     id_pc;
    logic [reg_aw-1:0]   id_rs1;
    logic [reg_aw-1:0]   id_rs2;
    logic [reg_aw-1:0]   id_rd;
    logic [xlen-1:0]     id_imm;
    logic [2:0]          id_funct3;
    logic [alu_w-1:0]    id_alu;
    logic [opc_w-1:0]    id_class;
    logic [exc_w-1:0]    id_exception;
    logic [xlen-1:0]     id_rs1_data;
    logic [xlen-1:0]     id_rs2_data;

    logic [ilen-1:0]     imem [0:255];
    logic [xlen-1:0]     shadow [0:31];
    logic [xlen-1:0]     pc_queue [$];
    logic [xlen-1:0]     model_addr;
    logic [255:0]        last_snap;
    int                  seed;
    int                  stall_left;
    int                  error_count;
    int                  check_count;
    int                  item_count;
    int                  exc_count;

    tb_clock #(.period_ns(clk_period)) i_clock (.d_clk(d_clk));

    rv_frontend i_dut (
        .d_clk        (d_clk),
        .d_rst        (d_rst),
        .stall        (stall),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .imem_addr    (imem_addr),
        .imem_rdata   (imem_rdata),
        .wb_en        (wb_en),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .id_valid     (id_valid),
        .id_pc        (id_pc),
        .id_rs1       (id_rs1),
        .id_rs2       (id_rs2),
        .id_rd        (id_rd),
        .id_imm       (id_imm),
        .id_funct3    (id_funct3),
        .id_alu       (id_alu),
        .id_class     (id_class),
        .id_exception (id_exception),
        .id_rs1_data  (id_rs1_data),
        .id_rs2_data  (id_rs2_data)
    );

    // instruction memory, word comes back one edge after the address
    always @(posedge d_clk) begin
        imem_rdata <= imem[imem_addr[9:2]];
    end

    task automatic check_eq(input logic [255:0] got, input logic [255:0] exp,
                            input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERR %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // ==================================================
    // random program
    // ==================================================
    function automatic logic [31:0] random_instr();
        logic [31:0] w;
        int          pick;
        w = $random(seed);
        pick = {$random(seed)} % 16;
        if (($random(seed) & 1) != 0) begin
            // keep both source fields in x0..x7 so write-backs hit them often
            w = w & ~32'h018c_0000;
        end
        case (pick)
            0, 11:   w[6:0] = opcode_rtype;
            1, 12:   w[6:0] = opcode_itype;
            2:       w[6:0] = opcode_load;
            3:       w[6:0] = opcode_store;
            4:       w[6:0] = opcode_branch;
            5:       w[6:0] = opcode_jal;
            6:       w[6:0] = opcode_jalr;
            7:       w[6:0] = opcode_lui;
            8:       w[6:0] = opcode_auipc;
            9, 13:   w[6:0] = opcode_system;
            10:      w[6:0] = opcode_fence;
            default: begin
                // random opcode, nearly always an illegal one
            end
        endcase
        if (w[6:0] == opcode_rtype || w[6:0] == opcode_itype) begin
            case ({$random(seed)} % 4)
                0, 1:    w[31:25] = 7'h00;
                2:       w[31:25] = 7'h20;
                default: begin
                end
            endcase
        end
        if (w[6:0] == opcode_system) begin
            if (($random(seed) & 3) != 0) w[14:12] = 3'b000;
            case ({$random(seed)} % 4)
                0:       w[31:20] = 12'h000;
                1:       w[31:20] = 12'h001;
                2:       w[31:20] = 12'h302;
                default: begin
                end
            endcase
        end
        return w;
    endfunction

    // ==================================================
    // reference decoder
    // ==================================================
    task automatic decode_ref(
        input  logic [31:0]      w,
        output logic [4:0]       rs1,
        output logic [4:0]       rs2,
        output logic [4:0]       rd,
        output logic [31:0]      imm,
        output logic [2:0]       f3,
        output logic [alu_w-1:0] alu,
        output logic [opc_w-1:0] cls,
        output logic [exc_w-1:0] exc
    );
        logic [6:0] f7;
        logic       f7_ok;
        f7 = w[31:25];
        f7_ok = (f7 == 7'h00) || (f7 == 7'h20);
        rs1 = 5'd0;
        rs2 = 5'd0;
        rd = 5'd0;
        imm = 32'd0;
        f3 = 3'd0;
        alu = '0;
        cls = '0;
        exc = '0;
        case (w[6:0])
            opcode_rtype:  cls[cls_rtype] = 1'b1;
            opcode_itype:  cls[cls_itype] = 1'b1;
            opcode_load:   cls[cls_load] = 1'b1;
            opcode_store:  cls[cls_store] = 1'b1;
            opcode_branch: cls[cls_branch] = 1'b1;
            opcode_jal:    cls[cls_jal] = 1'b1;
            opcode_jalr:   cls[cls_jalr] = 1'b1;
            opcode_lui:    cls[cls_lui] = 1'b1;
            opcode_auipc:  cls[cls_auipc] = 1'b1;
            opcode_system: cls[cls_system] = 1'b1;
            opcode_fence:  cls[cls_fence] = 1'b1;
            default:       exc[exc_illegal] = 1'b1;
        endcase

        // fields a format has no use for stay zero
        if (cls[cls_rtype] | cls[cls_store] | cls[cls_branch]) rs2 = w[24:20];
        if (cls != '0 && !(cls[cls_jal] | cls[cls_lui] | cls[cls_auipc])) begin
            rs1 = w[19:15];
            f3 = w[14:12];
        end
        if (cls != '0 && !(cls[cls_store] | cls[cls_branch])) rd = w[11:7];

        if (cls[cls_itype] | cls[cls_load] | cls[cls_jalr]) imm = {{20{w[31]}}, w[31:20]};
        if (cls[cls_store]) imm = {{20{w[31]}}, w[31:25], w[11:7]};
        if (cls[cls_branch]) imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        if (cls[cls_jal]) imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        if (cls[cls_lui] | cls[cls_auipc]) imm = {w[31:12], 12'h000};
        if (cls[cls_system] | cls[cls_fence]) imm = {20'h00000, w[31:20]};

        if (cls[cls_rtype] | cls[cls_itype]) begin
            case (w[14:12])
                3'd0: alu[(cls[cls_rtype] && w[30]) ? alu_sub : alu_add] = 1'b1;
                3'd1: alu[alu_sll] = 1'b1;
                3'd2: alu[alu_slt] = 1'b1;
                3'd3: alu[alu_sltu] = 1'b1;
                3'd4: alu[alu_xor] = 1'b1;
                3'd5: alu[w[30] ? alu_sra : alu_srl] = 1'b1;
                3'd6: alu[alu_or] = 1'b1;
                default: alu[alu_and] = 1'b1;
            endcase
        end else if (cls[cls_branch]) begin
            case (w[14:12])
                3'd0: alu[alu_eq] = 1'b1;
                3'd1: alu[alu_neq] = 1'b1;
                3'd4: alu[alu_lt] = 1'b1;
                3'd5: alu[alu_ge] = 1'b1;
                3'd6: alu[alu_ltu] = 1'b1;
                3'd7: alu[alu_geu] = 1'b1;
                default: alu[alu_add] = 1'b1;
            endcase
        end else begin
            alu[alu_add] = 1'b1;
        end

        if (cls[cls_rtype] && !f7_ok) exc[exc_illegal] = 1'b1;
        if (cls[cls_itype] && w[14:12] == 3'd1 && f7 != 7'h00) exc[exc_illegal] = 1'b1;
        if (cls[cls_itype] && w[14:12] == 3'd5 && !f7_ok) exc[exc_illegal] = 1'b1;
        if (cls[cls_system] && w[14:12] == 3'd0) begin
            case (w[31:20])
                12'h000: exc[exc_ecall] = 1'b1;
                12'h001: exc[exc_ebreak] = 1'b1;
                12'h302: exc[exc_mret] = 1'b1;
                default: exc[exc_illegal] = 1'b1;
            endcase
        end
    endtask

    // ==================================================
    // stimulus and checking
    // ==================================================
    function automatic logic [255:0] snapshot();
        return 256'({imem_addr, id_valid, id_pc, id_rs1, id_rs2, id_rd, id_imm, id_funct3,
                     id_alu, id_class, id_exception, id_rs1_data, id_rs2_data});
    endfunction

    task automatic drive_inputs(input bit use_wb, input bit use_stall, input bit use_redirect);
        logic [31:0] r;
        if (use_stall && stall_left == 0 && ($random(seed) & 7) == 0) begin
            stall_left = 1 + {$random(seed)} % 6;
        end
        stall = (stall_left != 0);
        if (stall_left != 0) stall_left--;
        // single-cycle pulse, never while stalled
        redirect = use_redirect && !stall && !redirect && (($random(seed) & 15) == 0);
        redirect_pc = $random(seed) & 32'h0000_03fc;
        r = $random(seed);
        wb_en = use_wb && r[0];
        wb_addr = r[1] ? {2'b00, r[4:2]} : r[9:5];
        wb_data = $random(seed);
    endtask

    // runs at the falling edge, inputs still show what the last rising edge saw
    task automatic check_cycle();
        logic [255:0]     now_snap;
        logic [31:0]      exp_pc;
        logic [4:0]       e_rs1;
        logic [4:0]       e_rs2;
        logic [4:0]       e_rd;
        logic [31:0]      e_imm;
        logic [2:0]       e_f3;
        logic [alu_w-1:0] e_alu;
        logic [opc_w-1:0] e_cls;
        logic [exc_w-1:0] e_exc;
        if (wb_en && wb_addr != 5'd0) shadow[wb_addr] = wb_data;
        if (!stall) begin
            if (redirect) begin
                // both words in flight belong to the old path
                pc_queue.delete();
                model_addr = redirect_pc;
            end else begin
                model_addr = model_addr + 32'd4;
            end
            pc_queue.push_back(model_addr);
        end
        check_eq(256'(imem_addr), 256'(model_addr), "imem_addr");
        now_snap = snapshot();
        if (stall) begin
            check_eq(now_snap, last_snap, "outputs under stall");
        end else begin
            check_eq(256'(id_valid), 256'(pc_queue.size() > 2), "id_valid");
            if (id_valid && pc_queue.size() > 2) begin
                exp_pc = pc_queue.pop_front();
                decode_ref(imem[exp_pc[9:2]], e_rs1, e_rs2, e_rd, e_imm, e_f3, e_alu, e_cls,
                           e_exc);
                item_count++;
                if (e_exc != '0) exc_count++;
                check_eq(256'(id_pc), 256'(exp_pc), "id_pc");
                check_eq(256'(id_rs1), 256'(e_rs1), "id_rs1");
                check_eq(256'(id_rs2), 256'(e_rs2), "id_rs2");
                check_eq(256'(id_rd), 256'(e_rd), "id_rd");
                check_eq(256'(id_imm), 256'(e_imm), "id_imm");
                check_eq(256'(id_funct3), 256'(e_f3), "id_funct3");
                check_eq(256'(id_alu), 256'(e_alu), "id_alu");
                check_eq(256'(id_class), 256'(e_cls), "id_class");
                check_eq(256'(id_exception), 256'(e_exc), "id_exception");
                check_eq(256'(id_rs1_data), 256'(shadow[e_rs1]), "id_rs1_data");
                check_eq(256'(id_rs2_data), 256'(shadow[e_rs2]), "id_rs2_data");
            end
        end
        last_snap = now_snap;
    endtask

    task automatic run_test(input string name, input int cycles, input bit use_wb,
                            input bit use_stall, input bit use_redirect);
        int errs_before;
        int items_before;
        int cyc;
        errs_before = error_count;
        items_before = item_count;
        for (cyc = 0; cyc < cycles; cyc++) begin
            drive_inputs(use_wb, use_stall, use_redirect);
            @(negedge d_clk);
            check_cycle();
        end
        if (item_count == items_before) begin
            error_count++;
            $display("test %s decoded no instructions at all", name);
        end
        $display("test %-8s %0d cycles, %0d items, %0d errors", name, cycles,
                 item_count - items_before, error_count - errs_before);
    endtask

    initial begin
        #(watchdog_ns);
        $display("watchdog: run did not finish within %0d ns", watchdog_ns);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        int idx;
        seed = 2294;
        stall_left = 0;
        error_count = 0;
        check_count = 0;
        item_count = 0;
        exc_count = 0;
        d_rst = 1'b0;
        stall = 1'b0;
        redirect = 1'b0;
        redirect_pc = '0;
        wb_en = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        for (idx = 0; idx < 256; idx++) begin
            imem[idx] = random_instr();
        end
        for (idx = 0; idx < 32; idx++) begin
            shadow[idx] = '0;
        end
        // reset_pc is on the bus when reset lifts
        model_addr = reset_pc;
        pc_queue.push_back(reset_pc);

        repeat (reset_cycles) @(posedge d_clk);
        @(negedge d_clk);
        d_rst = 1'b1;
        check_eq(256'(imem_addr), 256'(reset_pc), "imem_addr after reset");
        check_eq(256'(id_valid), 256'(0), "id_valid after reset");
        check_eq(256'(id_exception), 256'(0), "id_exception after reset");
        last_snap = snapshot();

        run_test("fetch", len_fetch, 1'b0, 1'b0, 1'b0);
        run_test("operand", len_operand, 1'b1, 1'b0, 1'b0);
        run_test("stall", len_stall, 1'b1, 1'b1, 1'b0);
        run_test("redirect", len_redirect, 1'b1, 1'b0, 1'b1);
        run_test("mixed", len_mixed, 1'b1, 1'b1, 1'b1);

        $display("checks %0d, items %0d, exceptions %0d, errors %0d", check_count,
                 item_count, exc_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rv_frontend.f
design/rv_pkg.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_frontend.sv
test/tb_clock.sv
test/tb_rv_frontend.sv

//--- run.sh
#!/usr/bin/env bash
# build the rv_frontend testbench with verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_rv_frontend -f rv_frontend.f \
    -o tb_rv_frontend --Mdir obj_dir \
    && ./obj_dir/tb_rv_frontend > sim.log 2>&1 \
    || echo "build or simulation did not complete" >> sim.log
cat sim.log
grep -qx "Finished with no errors" sim.log && exit 0 || exit 1
